//--- dv/scratch_tb.sv
`timescale 1ns/1ns

module scratch_tb;

  localparam int reset_cycles = 16;
  localparam int scan_timeout = 600;  // Enough for a 256 word scan plus host traffic
  localparam int quiet_window = 40;   // Cycles watched after a start that must be dropped

  logic                   clk;
  logic                   rst_n;
  scratch_pkg::host_req_t host;
  scratch_pkg::word_t     host_rdata;
  logic                   host_rvalid;
  scratch_pkg::stream_t   stream;

  scratch_pkg::word_t     mem_m [scratch_pkg::mem_depth]; // Reference copy of the RAM
  scratch_pkg::mem_addr_t base_m;    // Expected base register
  scratch_pkg::count_t    count_m;   // Expected count register
  logic                   busy_m;    // Expected status bit 0
  scratch_pkg::word_t     exp_q [$]; // Words the stream still owes
  int                     seed;
  int                     cyc;       // Falling edges seen since reset release
  int                     scan_cyc;  // Cycle in which the accepted ctrl write was driven

  tb_clk_gen #(.period(20)) i_clk_gen (.clk(clk));

  scratch_top i_scratch_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .host        (host),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .stream      (stream)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      fail_run($sformatf("Value mismatch on %s at cycle %0d", name, cyc));
    end
  endtask

  // Byte lanes of d replace those of old where we is set
  function automatic scratch_pkg::word_t merge_bytes(input scratch_pkg::word_t old,
                                                     input scratch_pkg::word_t d,
                                                     input scratch_pkg::byte_en_t we);
    scratch_pkg::word_t r;
    r = old;
    for (int i = 0; i < scratch_pkg::be_w; i++) begin
      if (we[i]) r[8*i +: 8] = d[8*i +: 8];
    end
    return r;
  endfunction

  function automatic scratch_pkg::word_t reg_value(input logic [1:0] off);
    scratch_pkg::word_t v;
    v = '0;
    case (off)
      scratch_pkg::reg_base:   v[7:0] = base_m;
      scratch_pkg::reg_count:  v[8:0] = count_m;
      scratch_pkg::reg_status: v[0]   = busy_m;
      default:                 v = '0;  // Ctrl is write only
    endcase
    return v;
  endfunction

  // Advance one cycle and check everything the DUT shows at the falling edge
  task automatic step();
    logic rv_exp;
    rv_exp = host.en;  // An access in the cycle now ending must answer in the next one
    @(negedge clk);
    cyc++;
    check("host_rvalid", host_rvalid, rv_exp);
    if (exp_q.size() != 0) begin
      // Owed words run back to back from the third cycle after the ctrl write
      check("stream.valid", stream.valid, (cyc - scan_cyc) >= 3);
    end
    if (stream.valid) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("Stream produced a word at cycle %0d with no scan running", cyc));
      end else begin
        check("stream.last", stream.last, exp_q.size() == 1);
        check("stream.data", stream.data, exp_q.pop_front());
      end
    end else begin
      check("stream.last", stream.last, 0);
    end
  endtask

  // One host access held for a single cycle with its answer checked one cycle later
  task automatic host_access(input scratch_pkg::host_addr_t addr,
                             input scratch_pkg::byte_en_t we,
                             input scratch_pkg::word_t wdata,
                             input scratch_pkg::word_t exp_rdata,
                             input bit check_data);
    step();
    host.en    = 1'b1;
    host.we    = we;
    host.addr  = addr;
    host.wdata = wdata;
    step();
    host.en = 1'b0;
    host.we = '0;
    if (check_data) check("host_rdata", host_rdata, exp_rdata);
  endtask

  task automatic mem_write(input scratch_pkg::mem_addr_t a, input scratch_pkg::byte_en_t we,
                           input scratch_pkg::word_t d, input bit check_old);
    host_access({1'b0, a}, we, d, mem_m[a], check_old); // Read-first gives the old word
    mem_m[a] = merge_bytes(mem_m[a], d, we);
  endtask

  task automatic mem_read(input scratch_pkg::mem_addr_t a);
    host_access({1'b0, a}, '0, scratch_pkg::word_t'($random(seed)), mem_m[a], 1'b1);
  endtask

  task automatic reg_access(input logic [1:0] off, input scratch_pkg::byte_en_t we,
                            input scratch_pkg::word_t wdata);
    scratch_pkg::host_addr_t addr;
    addr = {1'b1, 6'($random(seed)), off};  // Middle bits do not matter in register space
    host_access(addr, we, wdata, reg_value(off), 1'b1);
    if (off == scratch_pkg::reg_base && we[0]) base_m = wdata[7:0];
    if (off == scratch_pkg::reg_count) begin
      if (we[0]) count_m[7:0] = wdata[7:0];
      if (we[1]) count_m[8] = wdata[8];
    end
  endtask

  // Program a window, start it and follow the stream until it is done
  task automatic run_scan(input scratch_pkg::mem_addr_t base, input scratch_pkg::count_t count,
                          input bit poke);
    int waited;
    reg_access(scratch_pkg::reg_base, 4'b0001, scratch_pkg::word_t'(base));
    reg_access(scratch_pkg::reg_count, 4'b0011, scratch_pkg::word_t'(count));
    for (int i = 0; i < int'(count); i++) begin
      exp_q.push_back(mem_m[scratch_pkg::mem_addr_t'(int'(base) + i)]); // Wraps at 256
    end
    scan_cyc = cyc + 1;  // The ctrl write goes out after the next falling edge
    reg_access(scratch_pkg::reg_ctrl, 4'b0001, 32'h1);
    busy_m = (count != 0);
    if (poke) begin
      reg_access(scratch_pkg::reg_status, 4'b0000, '0);  // Busy while words are flowing
      reg_access(scratch_pkg::reg_ctrl, 4'b0001, 32'h1); // Must not add any words
      reg_access(scratch_pkg::reg_status, 4'b0000, '0);
    end
    waited = 0;
    while (exp_q.size() != 0 && waited < scan_timeout) begin
      step();
      waited++;
    end
    if (exp_q.size() != 0) begin
      fail_run($sformatf("Scan timed out with %0d words still missing", exp_q.size()));
    end else begin
      if (count == 0) begin
        for (int i = 0; i < quiet_window; i++) step(); // No word may appear in this window
      end
      busy_m = 1'b0;
      reg_access(scratch_pkg::reg_status, 4'b0000, '0);
    end
  endtask

  initial begin
    scratch_pkg::mem_addr_t a;
    scratch_pkg::byte_en_t  we;
    scratch_pkg::word_t     d;
    logic [1:0]             off;
    seed          = 62104;
    rst_n         = 1'b0;
    host          = '0;
    cyc           = 0;
    scan_cyc      = 0;
    base_m        = '0;
    count_m       = '0;
    busy_m        = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    check("stream.valid", stream.valid, 0);
    check("host_rvalid", host_rvalid, 0);

    // Registers come out of reset at zero
    reg_access(scratch_pkg::reg_base, 4'b0000, '0);
    reg_access(scratch_pkg::reg_count, 4'b0000, '0);
    reg_access(scratch_pkg::reg_status, 4'b0000, '0);

    // Fill every word while only rvalid is checked since the old contents are unknown
    for (int i = 0; i < scratch_pkg::mem_depth; i++) begin
      mem_write(scratch_pkg::mem_addr_t'(i), 4'hf, scratch_pkg::word_t'($random(seed)), 1'b0);
    end
    // Partial writes over all addresses return the words they overwrite
    for (int i = 0; i < scratch_pkg::mem_depth; i++) begin
      we = scratch_pkg::byte_en_t'($random(seed));
      if (we == '0) we = 4'b1000;
      mem_write(scratch_pkg::mem_addr_t'(i), we, scratch_pkg::word_t'($random(seed)), 1'b1);
    end
    for (int i = 0; i < 300; i++) begin
      mem_read(scratch_pkg::mem_addr_t'($random(seed)));
    end

    // Read-first on one address with a full word then a partial overwrite then a read
    for (int i = 0; i < 20; i++) begin
      a = scratch_pkg::mem_addr_t'($random(seed));
      mem_write(a, 4'hf, scratch_pkg::word_t'($random(seed)), 1'b1);
      mem_write(a, scratch_pkg::byte_en_t'($random(seed)), scratch_pkg::word_t'($random(seed)),
                1'b1);
      mem_read(a);
    end

    // Random register traffic where ctrl writes keep bit 0 clear so no scan starts
    for (int i = 0; i < 60; i++) begin
      off = 2'($random(seed));
      we  = scratch_pkg::byte_en_t'($random(seed));
      d   = scratch_pkg::word_t'($random(seed));
      if (off == scratch_pkg::reg_ctrl) d[0] = 1'b0;
      reg_access(off, we, d);
    end

    // Scans with a wrapping window, a full sweep and the smallest ones
    run_scan(8'd250, 9'd20, 1'b0);
    run_scan(scratch_pkg::mem_addr_t'($random(seed)), 9'd256, 1'b0);
    run_scan(8'd0, 9'd1, 1'b0);
    run_scan(8'd255, 9'd2, 1'b0);
    for (int i = 0; i < 8; i++) begin
      run_scan(scratch_pkg::mem_addr_t'($random(seed)),
               scratch_pkg::count_t'(($random(seed) & 255) + 1), 1'b0);
      mem_write(scratch_pkg::mem_addr_t'($random(seed)), 4'hf,
                scratch_pkg::word_t'($random(seed)), 1'b1); // Fresh data for the next window
    end

    // Status during a scan, a dropped second start and a dropped empty start
    run_scan(scratch_pkg::mem_addr_t'($random(seed)), 9'd40, 1'b1);
    run_scan(scratch_pkg::mem_addr_t'($random(seed)), 9'd0, 1'b0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period = 20  // Clock period in ns
) (
  output logic clk
);

  // Free-running clock, starts low so the first rising edge is at half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

//--- logic/block_scanner.sv
`timescale 1ns/1ns

module block_scanner (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  scratch_pkg::scan_cfg_t cfg,
  output logic                   enb,
  output scratch_pkg::mem_addr_t addrb,
  input  scratch_pkg::word_t     doutb,
  input  logic                   validb,
  output logic                   busy,
  output scratch_pkg::stream_t   out
);

  scratch_pkg::scan_state_t state_q;
  scratch_pkg::scan_state_t state_d;

  scratch_pkg::mem_addr_t addr_q;    // Next word address to read
  scratch_pkg::count_t    remain_q;  // Reads still to issue counting the current one
  logic                   final_rd;  // This cycle issues the last read
  logic                   final_q;   // Last read's data is on doutb now
  logic                   accept;    // Start taken from idle with a nonzero count

  // Starts while busy or with an empty window are dropped here
  assign accept = (state_q == scratch_pkg::idle) && start && (cfg.count != '0);

  assign final_rd = (state_q == scratch_pkg::run) && (remain_q == scratch_pkg::count_t'(1));

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      scratch_pkg::idle: begin
        if (accept) state_d = scratch_pkg::run;
      end
      scratch_pkg::run: begin
        if (final_rd) state_d = scratch_pkg::drain;
      end
      scratch_pkg::drain: begin
        if (validb && final_q) state_d = scratch_pkg::idle; // Last word leaves now
      end
      default: state_d = scratch_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= scratch_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Address and word counter load on an accepted start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q   <= '0;
      remain_q <= '0;
    end else if (accept) begin
      addr_q   <= cfg.base;
      remain_q <= cfg.count;
    end else if (state_q == scratch_pkg::run) begin
      addr_q   <= addr_q + 1'b1;  // Wraps at the top of the array
      remain_q <= remain_q - 1'b1;
    end
  end

  // Lines up with the one-cycle RAM latency so last marks the right word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      final_q <= 1'b0;
    end else begin
      final_q <= final_rd;
    end
  end

  // One read per cycle while running
  assign enb   = (state_q == scratch_pkg::run);
  assign addrb = addr_q;

  // Busy covers the whole scan from the first read until the last word is out
  assign busy = (state_q != scratch_pkg::idle);

  // The stream is the port B answer with last on the final word
  assign out.valid = validb;
  assign out.last  = validb && final_q;
  assign out.data  = doutb;

endmodule

//--- logic/scan_regs.sv
`timescale 1ns/1ns

module scan_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  scratch_pkg::host_req_t req,   // Already qualified for register space
  input  logic                   busy,  // From the scanner, shown in status
  output scratch_pkg::scan_cfg_t cfg,
  output logic                   start,
  output scratch_pkg::word_t     rdata,
  output logic                   rvalid
);

  scratch_pkg::mem_addr_t base_q;  // Scan base word address
  scratch_pkg::count_t    count_q; // Scan length in words
  scratch_pkg::word_t     rd_val;  // Read value of the addressed register

  logic [1:0] reg_idx;   // Register offset within the block
  logic       wr_base;   // Write strobe for the base register
  logic       wr_count;  // Write strobe for the count register
  logic       wr_start;  // Ctrl write that requests a scan

  assign reg_idx = req.addr[1:0];

  // A write is any access with at least one byte enable
  assign wr_base  = req.en && (|req.we) && (reg_idx == scratch_pkg::reg_base);
  assign wr_count = req.en && (|req.we) && (reg_idx == scratch_pkg::reg_count);

  // Only byte 0 bit 0 of a ctrl write matters
  assign wr_start = req.en && req.we[0] && (reg_idx == scratch_pkg::reg_ctrl)
                    && req.wdata[0];

  // Configuration registers, each byte lane only under its enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_base && req.we[0]) begin
        base_q <= req.wdata[scratch_pkg::addr_w-1:0];
      end
      if (wr_count) begin
        if (req.we[0]) count_q[7:0] <= req.wdata[7:0];   // Low byte of the count
        if (req.we[1]) count_q[8]   <= req.wdata[8];     // Top bit lives in byte 1
      end
    end
  end

  // Start is a single-cycle pulse, the scanner decides whether to accept it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start <= 1'b0;
    end else begin
      start <= wr_start;
    end
  end

  // Read mux over the current values, so a read in a write cycle sees the old value
  always_comb begin
    rd_val = '0;
    case (reg_idx)
      scratch_pkg::reg_base:   rd_val[scratch_pkg::addr_w-1:0]  = base_q;
      scratch_pkg::reg_count:  rd_val[scratch_pkg::count_w-1:0] = count_q;
      scratch_pkg::reg_status: rd_val[0] = busy;
      default:                 rd_val = '0; // Ctrl has no readable state
    endcase
  end

  // Read data register, updated only on an access
  always_ff @(posedge clk) begin
    if (req.en) begin
      rdata <= rd_val;
    end
  end

  // Every access answers one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= req.en;
    end
  end

  assign cfg.base  = base_q;
  assign cfg.count = count_q;

endmodule

//--- logic/scratch_bram.sv
`timescale 1ns/1ns

module scratch_bram #(
  parameter int width = scratch_pkg::data_w,
  parameter int depth = scratch_pkg::mem_depth
) (
  input  logic                     clk,

  // Port A is read/write with byte enables
  input  logic                     ena,
  input  logic [width/8-1:0]       wea,
  input  logic [$clog2(depth)-1:0] addra,
  input  logic [width-1:0]         dina,
  output logic [width-1:0]         douta,

  // Port B is read only
  input  logic                     enb,
  input  logic [$clog2(depth)-1:0] addrb,
  output logic [width-1:0]         doutb,
  output logic                     validb
);

  localparam int lanes = width / 8; // Byte lanes per word

  logic [width-1:0] ram [depth];    // Storage array, contents survive reset

  // Port A, the registered read sees the word before this cycle's write
  always_ff @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < lanes; i++) begin
        if (wea[i]) begin
          ram[addra][8*i +: 8] <= dina[8*i +: 8]; // Only enabled lanes change
        end
      end
      douta <= ram[addra]; // Old word, since the write above lands at the edge
    end
  end

  // Port B read path
  always_ff @(posedge clk) begin
    if (enb) begin
      doutb <= ram[addrb];
    end
  end

  // Valid tracks the read enable with the same one-cycle latency as the data
  always_ff @(posedge clk) begin
    validb <= enb;
  end

endmodule

//--- logic/scratch_pkg.sv
package scratch_pkg;

  // Memory geometry
  localparam int data_w = 32;               // Width of one scratchpad word
  localparam int mem_depth = 256;           // Number of words in the array
  localparam int be_w = data_w / 8;         // One enable per byte lane
  localparam int addr_w = $clog2(mem_depth); // Word address width, 8 for 256 words

  // Host address space, the top bit picks the register block over the memory
  localparam int host_addr_w = addr_w + 1;
  localparam int reg_sel_bit = host_addr_w - 1;

  // Register map, decoded from the two low host address bits
  localparam logic [1:0] reg_base   = 2'd0; // Scan start word address
  localparam logic [1:0] reg_count  = 2'd1; // Number of words to scan
  localparam logic [1:0] reg_ctrl   = 2'd2; // Bit 0 written as one starts a scan
  localparam logic [1:0] reg_status = 2'd3; // Bit 0 is the scanner busy flag

  // Width of the word counter, one wider than an address so a full sweep fits
  localparam int count_w = addr_w + 1;

  typedef logic [data_w-1:0]      word_t;
  typedef logic [addr_w-1:0]      mem_addr_t;
  typedef logic [be_w-1:0]        byte_en_t;
  typedef logic [count_w-1:0]     count_t;
  typedef logic [host_addr_w-1:0] host_addr_t;

  // One host access, a read when no byte enable is set
  typedef struct packed {
    logic       en;
    byte_en_t   we;
    host_addr_t addr;
    word_t      wdata;
  } host_req_t;

  // Scan window held by the register block
  typedef struct packed {
    mem_addr_t base;
    count_t    count;
  } scan_cfg_t;

  // Output word stream, no back-pressure
  typedef struct packed {
    logic  valid;
    logic  last;
    word_t data;
  } stream_t;

  typedef enum logic [1:0] {
    idle  = 2'd0,  // Waiting for a start
    run   = 2'd1,  // Issuing one port B read per cycle
    drain = 2'd2   // Last read is in flight
  } scan_state_t;

endpackage

//--- logic/scratch_top.sv
`timescale 1ns/1ns

module scratch_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  scratch_pkg::host_req_t host,
  output scratch_pkg::word_t     host_rdata,
  output logic                   host_rvalid,
  output scratch_pkg::stream_t   stream
);

  scratch_pkg::host_req_t regs_req;     // Host request seen by the register block
  scratch_pkg::scan_cfg_t scan_cfg;
  scratch_pkg::word_t     douta;        // Port A read data
  scratch_pkg::word_t     doutb;        // Port B read data
  scratch_pkg::word_t     regs_rdata;
  scratch_pkg::mem_addr_t addrb;

  logic reg_sel;      // Current access targets the registers
  logic mem_en;       // Current access targets the memory
  logic reg_sel_q;    // Target of last cycle's access, steers the read mux
  logic mem_rvalid_q; // Memory access answered this cycle
  logic regs_rvalid;
  logic scan_start;
  logic scan_busy;
  logic enb;
  logic validb;

  assign reg_sel = host.addr[scratch_pkg::reg_sel_bit];
  assign mem_en  = host.en && !reg_sel;

  // Same request, but only enabled for register space
  always_comb begin
    regs_req    = host;
    regs_req.en = host.en && reg_sel;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_sel_q    <= 1'b0;
      mem_rvalid_q <= 1'b0;
    end else begin
      reg_sel_q    <= reg_sel;
      mem_rvalid_q <= mem_en;  // Matches the RAM's one-cycle read latency
    end
  end

  // Registered select bit decides where the answer comes from
  assign host_rdata  = reg_sel_q ? regs_rdata : douta;
  assign host_rvalid = reg_sel_q ? regs_rvalid : mem_rvalid_q;

  scratch_bram i_bram (
    .clk    (clk),
    .ena    (mem_en),
    .wea    (host.we),
    .addra  (host.addr[scratch_pkg::addr_w-1:0]),
    .dina   (host.wdata),
    .douta  (douta),
    .enb    (enb),
    .addrb  (addrb),
    .doutb  (doutb),
    .validb (validb)
  );

  scan_regs i_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (regs_req),
    .busy   (scan_busy),
    .cfg    (scan_cfg),
    .start  (scan_start),
    .rdata  (regs_rdata),
    .rvalid (regs_rvalid)
  );

  block_scanner i_scanner (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (scan_start),
    .cfg    (scan_cfg),
    .enb    (enb),
    .addrb  (addrb),
    .doutb  (doutb),
    .validb (validb),
    .busy   (scan_busy),
    .out    (stream)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module scratch_tb -f src.f -o sim_scratch \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_scratch > sim.log 2>&1

grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- src.f
logic/scratch_pkg.sv
logic/scratch_bram.sv
logic/scan_regs.sv
logic/block_scanner.sv
logic/scratch_top.sv
dv/tb_clk_gen.sv
dv/scratch_tb.sv
